//--- hdl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Word addresses used by the core and the memory model

// First instruction fetched after reset or after halt is released
`define RESET_VECTOR 32'h0000_0100

// Slot that receives the interrupted instruction address on a trap
`define TRAP_ADDR 32'h0000_00FF

// Base of the throw vector table, indexed by the 5-bit vector field
`define VECTOR_ADDR 32'h0000_00E0

// Entry point of the trap handler
`define TRAMP_BOTTOM 32'h0000_00C0

`endif

//--- hdl/isaPkg.sv
package isaPkg;

    // Arithmetic operation applied to A and B before C is added
    typedef enum logic [3:0] {
        OP_OR   = 4'd0,
        OP_AND  = 4'd1,
        OP_ADD  = 4'd2,
        OP_MUL  = 4'd3,
        OP_SHL  = 4'd5,
        OP_LT   = 4'd6,
        OP_EQ   = 4'd7,
        OP_GE   = 4'd8,
        OP_ANDN = 4'd9,
        OP_XOR  = 4'd10,
        OP_SUB  = 4'd11,
        OP_XNOR = 4'd12,
        OP_SHR  = 4'd13,
        OP_NE   = 4'd14,
        OP_SAR  = 4'd15
    } opcodeT;

    // Operand shuffle, named by the A/B/C sources
    typedef enum logic [1:0] {
        KIND_XYI   = 2'd0,
        KIND_XIY   = 2'd1,
        KIND_IXY   = 2'd2,
        KIND_THROW = 2'd3
    } kindT;

    // Fields of one instruction after decode
    typedef struct packed {
        kindT        kind;
        logic        storing;
        logic        derefRhs;
        logic [3:0]  idxZ;
        logic [3:0]  idxX;
        logic [3:0]  idxY;
        opcodeT      op;
        logic [31:0] imm;
        logic [4:0]  vector;
        logic        branch;
    } decodedInsnT;

endpackage

//--- hdl/corePkg.sv
package corePkg;

    typedef enum logic [3:0] {
        IDLE,
        EXEC,
        WAITX,
        SETTLE,
        MEM,
        COMMIT,
        NEXTPC,
        FETCH,
        THROW,
        VECREAD,
        TRAPIN,
        SAVE,
        JUMP
    } seqStateT;

    // Shuffled operands for Z = (A op B) + C
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } operandsT;

    // Data port toward memory, rw high means write
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        rw;
    } dataReqT;

endpackage

//--- hdl/regFile.sv
module regFile (
    input  logic        clk,
    input  logic        we,
    input  logic [3:0]  idxZ,
    input  logic [3:0]  idxX,
    input  logic [3:0]  idxY,
    input  logic [31:0] writeValue,
    input  logic [31:0] nextPc,
    output logic [31:0] valZ,
    output logic [31:0] valX,
    output logic [31:0] valY
);

    // Only registers 1 to 14 are stored
    logic [31:0] regs [1:14];

    function automatic logic [31:0] readReg(logic [3:0] idx);
        if (idx == 4'd0)
            return 32'd0;
        else if (idx == 4'd15)
            return nextPc;
        else
            return regs[idx];
    endfunction

    assign valZ = readReg(idxZ);
    assign valX = readReg(idxX);
    assign valY = readReg(idxY);

    // Writes to r0 and to the program counter slot are dropped
    always_ff @(posedge clk) begin
        if (we && idxZ != 4'd0 && idxZ != 4'd15) begin
            regs[idxZ] <= writeValue;
        end
    end

endmodule

//--- hdl/insnDecode.sv
module insnDecode
    import isaPkg::*, corePkg::*;
(
    input  logic [31:0] insn,
    input  logic [31:0] valX,
    input  logic [31:0] valY,
    output decodedInsnT dec,
    output operandsT    operands
);

    // Field split of the instruction word
    always_comb begin
        dec.kind     = kindT'(insn[31:30]);
        dec.storing  = insn[29];
        dec.derefRhs = insn[28];
        dec.idxZ     = insn[27:24];
        dec.idxX     = insn[23:20];
        dec.idxY     = insn[19:16];
        dec.op       = opcodeT'(insn[15:12]);
        dec.imm      = {{20{insn[11]}}, insn[11:0]};
        dec.vector   = insn[4:0];
        dec.branch   = (insn[27:24] == 4'd15) && !insn[29];
    end

    // Operand shuffle selected by kind
    always_comb begin
        case (dec.kind)
            KIND_XYI: begin
                operands.a = valX;
                operands.b = valY;
                operands.c = dec.imm;
            end
            KIND_XIY: begin
                operands.a = valX;
                operands.b = dec.imm;
                operands.c = valY;
            end
            KIND_IXY: begin
                operands.a = dec.imm;
                operands.b = valX;
                operands.c = valY;
            end
            default: begin
                // Throw has no arithmetic
                operands = '0;
            end
        endcase
    end

endmodule

//--- hdl/execUnit.sv
module execUnit
    import isaPkg::*, corePkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        start,
    input  opcodeT      op,
    input  operandsT    operands,
    output logic [31:0] result,
    output logic        done
);

    logic        s1Valid;
    opcodeT      s1Op;
    operandsT    s1Operands;
    logic        s2Valid;
    logic [31:0] s2Value;

    function automatic logic [31:0] applyOp(opcodeT code, operandsT ops);
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic [31:0]        t;
        a = ops.a;
        b = ops.b;
        case (code)
            OP_OR:   t = a | b;
            OP_AND:  t = a & b;
            OP_ADD:  t = a + b;
            OP_MUL:  t = a * b;
            OP_SHL:  t = a << b;
            OP_LT:   t = {32{a < b}};
            OP_EQ:   t = {32{a == b}};
            OP_GE:   t = {32{a >= b}};
            OP_ANDN: t = a & ~b;
            OP_XOR:  t = a ^ b;
            OP_SUB:  t = a - b;
            OP_XNOR: t = a ~^ b;
            OP_SHR:  t = a >> b;
            OP_NE:   t = {32{a != b}};
            OP_SAR:  t = a >>> b;
            // Unused code 4 contributes nothing, so only C remains
            default: t = 32'd0;
        endcase
        return t + ops.c;
    endfunction

    // Valid bits walk through the three stages
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            done    <= 1'b0;
        end else begin
            s1Valid <= start;
            s2Valid <= s1Valid;
            done    <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1Op       <= op;
            s1Operands <= operands;
        end
        if (s1Valid) begin
            s2Value <= applyOp(s1Op, s1Operands);
        end
        if (s2Valid) begin
            result <= s2Value;
        end
    end

endmodule

//--- hdl/memAccess.sv
`include "cpu_defines.svh"

module memAccess
    import isaPkg::*, corePkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  seqStateT    state,
    input  decodedInsnT dec,
    input  logic [31:0] result,
    input  logic [31:0] valZ,
    input  logic [31:0] savedPc,
    input  logic [31:0] dIn,
    output dataReqT     dReq,
    output logic        strobe,
    output logic [31:0] writeValue,
    output logic [31:0] vectorTarget
);

    logic        isLoad;
    logic        afterSave;
    logic [31:0] loadData;

    assign isLoad = dec.derefRhs && !dec.storing;

    // Trap save is the only write issued outside MEM
    assign strobe = (state == MEM && (isLoad || dec.storing))
                 || (state == JUMP && afterSave);

    always_comb begin
        dReq.rw = strobe && (dec.storing || state == JUMP);
        case (state)
            THROW, VECREAD: begin
                dReq.addr  = `VECTOR_ADDR + {27'd0, dec.vector};
                dReq.wdata = 32'd0;
            end
            SAVE, JUMP: begin
                dReq.addr  = `TRAP_ADDR;
                dReq.wdata = savedPc;
            end
            default: begin
                dReq.addr  = dec.derefRhs ? result : valZ;
                dReq.wdata = dec.derefRhs ? valZ : result;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            afterSave <= 1'b0;
        else
            afterSave <= (state == SAVE);
    end

    always_ff @(posedge clk) begin
        if (state == MEM && isLoad)
            loadData <= dIn;
        if (state == VECREAD)
            vectorTarget <= dIn;
    end

    assign writeValue = isLoad ? loadData : result;

endmodule

//--- hdl/coreSequencer.sv
`include "cpu_defines.svh"

module coreSequencer
    import isaPkg::*, corePkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        halt,
    input  logic        trap,
    input  logic [31:0] iData,
    input  decodedInsnT dec,
    input  logic        done,
    input  logic [31:0] writeValue,
    input  logic [31:0] vectorTarget,
    output seqStateT    state,
    output logic [31:0] insn,
    output logic [31:0] iAddr,
    output logic [31:0] nextPc,
    output logic        start,
    output logic        regWe
);

    logic isThrow;
    logic trapping;

    assign isThrow = (dec.kind == KIND_THROW);

    // Only ordinary instructions enter the arithmetic unit
    assign start = (state == EXEC) && !halt && !trap && !isThrow;
    assign regWe = (state == COMMIT) && !dec.storing;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= IDLE;
            trapping <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!halt)
                        state <= NEXTPC;
                end
                EXEC: begin
                    // Halt first, then trap, then throw
                    if (halt) begin
                        state <= IDLE;
                    end else if (trap) begin
                        state    <= TRAPIN;
                        trapping <= 1'b1;
                    end else if (isThrow) begin
                        state <= THROW;
                    end else begin
                        state <= WAITX;
                    end
                end
                WAITX: begin
                    if (done)
                        state <= SETTLE;
                end
                SETTLE:  state <= MEM;
                MEM:     state <= COMMIT;
                COMMIT:  state <= NEXTPC;
                NEXTPC:  state <= FETCH;
                FETCH:   state <= EXEC;
                THROW:   state <= VECREAD;
                VECREAD: state <= JUMP;
                TRAPIN:  state <= SAVE;
                SAVE:    state <= JUMP;
                JUMP: begin
                    state    <= NEXTPC;
                    trapping <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Program counter and instruction register
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (!halt)
                    iAddr <= `RESET_VECTOR;
            end
            COMMIT:  iAddr  <= dec.branch ? writeValue : nextPc;
            JUMP:    iAddr  <= trapping ? `TRAMP_BOTTOM : vectorTarget;
            NEXTPC:  nextPc <= iAddr + 32'd1;
            FETCH:   insn   <= iData;
            default: ;
        endcase
    end

endmodule

//--- hdl/cpuCore.sv
module cpuCore
    import isaPkg::*, corePkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        halt,
    input  logic        trap,
    output logic [31:0] iAddr,
    input  logic [31:0] iData,
    output logic        strobe,
    output dataReqT     dReq,
    input  logic [31:0] dIn
);

    seqStateT    state;
    decodedInsnT dec;
    operandsT    operands;
    logic [31:0] insn;
    logic [31:0] nextPc;
    logic [31:0] valZ;
    logic [31:0] valX;
    logic [31:0] valY;
    logic [31:0] result;
    logic [31:0] writeValue;
    logic [31:0] vectorTarget;
    logic        start;
    logic        done;
    logic        regWe;

    regFile i_regFile (
        .clk(clk), .we(regWe), .idxZ(dec.idxZ), .idxX(dec.idxX), .idxY(dec.idxY),
        .writeValue(writeValue), .nextPc(nextPc), .valZ(valZ), .valX(valX), .valY(valY)
    );

    insnDecode i_insnDecode (
        .insn(insn), .valX(valX), .valY(valY), .dec(dec), .operands(operands)
    );

    execUnit i_execUnit (
        .clk(clk), .reset_n(reset_n), .start(start), .op(dec.op),
        .operands(operands), .result(result), .done(done)
    );

    // The interrupted instruction address is what a trap saves
    memAccess i_memAccess (
        .clk(clk), .reset_n(reset_n), .state(state), .dec(dec), .result(result),
        .valZ(valZ), .savedPc(iAddr), .dIn(dIn), .dReq(dReq), .strobe(strobe),
        .writeValue(writeValue), .vectorTarget(vectorTarget)
    );

    coreSequencer i_coreSequencer (
        .clk(clk), .reset_n(reset_n), .halt(halt), .trap(trap), .iData(iData),
        .dec(dec), .done(done), .writeValue(writeValue), .vectorTarget(vectorTarget),
        .state(state), .insn(insn), .iAddr(iAddr), .nextPc(nextPc),
        .start(start), .regWe(regWe)
    );

endmodule

//--- tests/clockGen.sv
module clockGen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

//--- tests/cpuCore_chk.sv
`include "cpu_defines.svh"

module cpuCore_chk
    import corePkg::*;
(
    input logic        clk,
    input logic        reset_n,
    input logic        halt,
    input logic        strobe,
    input dataReqT     dReq,
    input logic [31:0] iAddr,
    input seqStateT    state,
    input logic        branch
);

    int          failCount = 0;
    logic [31:0] commitAddr;

    function automatic void noteFail(string msg);
        failCount++;
        $error("%s", msg);
    endfunction

    // Address of the instruction in COMMIT, used by the branch check
    always_ff @(posedge clk) begin
        if (state == COMMIT)
            commitAddr <= iAddr;
    end

    // A held core must stay quiet on the following cycle too
    quietStrobe: assert property (@(posedge clk)
        (!reset_n || (halt && state == IDLE)) |=> !strobe)
        else noteFail("Strobe was raised during reset or while halted");

    firstFetch: assert property (@(posedge clk)
        $rose(reset_n) && !halt |=> iAddr == `RESET_VECTOR)
        else noteFail($sformatf("Fail first fetch: expected %h actual %h",
            `RESET_VECTOR, $sampled(iAddr)));

    singleStrobe: assert property (@(posedge clk) disable iff (!reset_n)
        strobe |=> !strobe)
        else noteFail("Strobe stayed high for two cycles");

    // Every strobe toward a store target carries the write level
    storeIsWrite: assert property (@(posedge clk) disable iff (!reset_n)
        strobe && ((dReq.addr >= tbTop.resultBase && dReq.addr < tbTop.resultEnd)
            || dReq.addr == tbTop.moveAddr) |-> dReq.rw)
        else noteFail("A store strobe came without the write level");

    opcodeTable: assert property (@(posedge clk) disable iff (!reset_n)
        strobe && dReq.rw && dReq.addr >= tbTop.resultBase && dReq.addr < tbTop.resultEnd
        |-> dReq.wdata == tbTop.expStore[dReq.addr[5:0]])
        else noteFail($sformatf("Fail opcode table at %h: expected %h actual %h",
            $sampled(dReq.addr), tbTop.expStore[$sampled(dReq.addr[5:0])],
            $sampled(dReq.wdata)));

    movedWord: assert property (@(posedge clk) disable iff (!reset_n)
        strobe && dReq.rw && dReq.addr == tbTop.moveAddr |-> dReq.wdata == tbTop.moveWord)
        else noteFail($sformatf("Fail load and deref store: expected %h actual %h",
            tbTop.moveWord, $sampled(dReq.wdata)));

    branchTarget: assert property (@(posedge clk) disable iff (!reset_n)
        state == COMMIT && branch |=> iAddr == tbTop.branchTo[commitAddr[9:0]])
        else noteFail($sformatf("Fail branch: expected %h actual %h",
            tbTop.branchTo[commitAddr[9:0]], $sampled(iAddr)));

    throwRead: assert property (@(posedge clk) disable iff (!reset_n)
        state == VECREAD |-> !dReq.rw && dReq.addr == `VECTOR_ADDR + {27'd0, tbTop.throwVector})
        else noteFail("Throw vector read used the wrong address or a write level");

    throwJump: assert property (@(posedge clk) disable iff (!reset_n)
        state == VECREAD |-> ##2 iAddr == tbTop.throwTarget)
        else noteFail($sformatf("Fail throw target: expected %h actual %h",
            tbTop.throwTarget, $sampled(iAddr)));

    trapWrite: assert property (@(posedge clk) disable iff (!reset_n)
        state == SAVE |=> strobe && dReq.rw && dReq.addr == `TRAP_ADDR)
        else noteFail("Trap entry did not write the trap slot");

    trapSave: assert property (@(posedge clk) disable iff (!reset_n)
        strobe && dReq.rw && dReq.addr == `TRAP_ADDR |-> dReq.wdata == tbTop.trapFrom)
        else noteFail($sformatf("Fail trap save: expected %h actual %h",
            tbTop.trapFrom, $sampled(dReq.wdata)));

    trapJump: assert property (@(posedge clk) disable iff (!reset_n)
        strobe && dReq.rw && dReq.addr == `TRAP_ADDR |=> iAddr == `TRAMP_BOTTOM)
        else noteFail($sformatf("Fail trap handler fetch: expected %h actual %h",
            `TRAMP_BOTTOM, $sampled(iAddr)));

endmodule

//--- tests/tbTop.sv
`include "cpu_defines.svh"

module tbTop
    import isaPkg::*, corePkg::*;
();

    logic        clk;
    logic        reset_n;
    logic        halt;
    logic        trap;
    logic        strobe;
    logic [31:0] iAddr;
    logic [31:0] iData;
    logic [31:0] dIn;
    dataReqT     dReq;

    // Word-addressed memory, reloaded from image while reset is low
    logic [31:0] mem [0:1023];
    logic [31:0] image [0:1023];

    // Expected values read by the bound checker
    logic [31:0] expStore [0:63];
    logic [31:0] branchTo [0:1023];
    logic [31:0] resultBase;
    logic [31:0] resultEnd;
    logic [31:0] moveAddr;
    logic [31:0] moveWord;
    logic [31:0] throwTarget;
    logic [4:0]  throwVector;
    logic [31:0] trapFrom;

    int          timeouts;
    int          pc;
    logic        ok;

    clockGen i_clockGen (.clk(clk), .reset_n(reset_n));

    cpuCore i_dut (
        .clk(clk), .reset_n(reset_n), .halt(halt), .trap(trap), .iAddr(iAddr),
        .iData(iData), .strobe(strobe), .dReq(dReq), .dIn(dIn)
    );

    bind cpuCore cpuCore_chk i_chk (
        .clk(clk), .reset_n(reset_n), .halt(halt), .strobe(strobe), .dReq(dReq),
        .iAddr(iAddr), .state(state), .branch(dec.branch)
    );

    assign iData = mem[iAddr[9:0]];
    assign dIn   = mem[dReq.addr[9:0]];

    always @(posedge clk) begin
        if (!reset_n)
            mem <= image;
        else if (strobe && dReq.rw)
            mem[dReq.addr[9:0]] <= dReq.wdata;
    end

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encode(kindT kind, logic st, logic dr, logic [3:0] z,
            logic [3:0] x, logic [3:0] y, opcodeT op, logic [11:0] imm);
        return {kind, st, dr, z, x, y, op, imm};
    endfunction

    // Z = (A op B) + C, compares are signed and give all ones when true
    function automatic logic [31:0] expectResult(opcodeT op, logic [31:0] a, logic [31:0] b,
            logic [31:0] c);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        t;
        sa = a;
        sb = b;
        case (op)
            OP_OR:   t = a | b;
            OP_AND:  t = a & b;
            OP_ADD:  t = a + b;
            OP_MUL:  t = a * b;
            OP_SHL:  t = a << b;
            OP_LT:   t = (sa < sb) ? '1 : '0;
            OP_EQ:   t = (a == b) ? '1 : '0;
            OP_GE:   t = (sa >= sb) ? '1 : '0;
            OP_ANDN: t = a & ~b;
            OP_XOR:  t = a ^ b;
            OP_SUB:  t = a - b;
            OP_XNOR: t = ~(a ^ b);
            OP_SHR:  t = a >> b;
            OP_NE:   t = (a != b) ? '1 : '0;
            OP_SAR:  t = sa >>> b;
            default: t = '0;
        endcase
        return t + c;
    endfunction

    task automatic place(logic [31:0] word);
        image[pc] = word;
        pc++;
    endtask

    task automatic waitForAddr(logic [31:0] target, int limit, string what, output logic found);
        int n;
        n = 0;
        while (iAddr !== target && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        found = (iAddr === target);
        if (!found) begin
            timeouts++;
            $display("Timeout: the core never fetched %s at %h", what, target);
        end
    endtask

    // Counts k NOP fetches past 0x1B0, then holds trap until the trap slot is written
    task automatic raiseTrap(output logic found);
        int          k;
        int          n;
        int          seen;
        logic [31:0] prev;
        k = 1 + int'($urandom % 8);
        n = 0;
        seen = 0;
        prev = iAddr;
        found = 1'b0;
        while (seen < k && n < 200) begin
            @(posedge clk);
            #1;
            n++;
            if (iAddr != prev) begin
                seen++;
                prev = iAddr;
            end
        end
        if (seen < k) begin
            timeouts++;
            $display("Timeout: the core stopped fetching NOPs before the trap");
        end else begin
            trapFrom = 32'h1B0 + 32'(k);
            trap = 1'b1;
            n = 0;
            while (!(strobe && dReq.rw && dReq.addr == `TRAP_ADDR) && n < 40) begin
                @(posedge clk);
                #1;
                n++;
            end
            found = strobe && dReq.rw && dReq.addr == `TRAP_ADDR;
            trap = 1'b0;
            if (!found) begin
                timeouts++;
                $display("Timeout: the trap never wrote the trap slot");
            end
        end
    endtask

    task automatic endRun();
        $display("Error count: %0d assertion failures, %0d timeouts",
            i_dut.i_chk.failCount, timeouts);
        if (i_dut.i_chk.failCount == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        int          n;
        logic [11:0] imm;
        logic [11:0] r1Imm;
        logic [31:0] r1;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        void'($urandom(32'hc1aeed9e));
        halt = 1'b0;
        trap = 1'b0;
        timeouts = 0;
        for (int i = 0; i < 1024; i++) begin
            image[i] = '0;
            branchTo[i] = '0;
        end
        // r1 random, r2 = 5, r3 is the result pointer
        pc = 32'h100;
        r1Imm = 12'($urandom);
        r1 = sext12(r1Imm);
        place(encode(KIND_XYI, 1'b0, 1'b0, 4'd1, 4'd0, 4'd0, OP_ADD, r1Imm));
        place(encode(KIND_XYI, 1'b0, 1'b0, 4'd2, 4'd0, 4'd0, OP_ADD, 12'd5));
        place(encode(KIND_XYI, 1'b0, 1'b0, 4'd3, 4'd0, 4'd0, OP_ADD, 12'h200));
        resultBase = 32'h200;
        n = 0;
        for (int k = 0; k < 3; k++) begin
            for (int code = 0; code < 16; code++) begin
                if (code != 4) begin
                    imm = 12'($urandom);
                    a = (k == 2) ? sext12(imm) : r1;
                    b = (k == 0) ? 32'd5 : ((k == 1) ? sext12(imm) : r1);
                    c = (k == 0) ? sext12(imm) : 32'd5;
                    expStore[n] = expectResult(opcodeT'(code[3:0]), a, b, c);
                    place(encode(kindT'(k[1:0]), 1'b1, 1'b0, 4'd3, 4'd1, 4'd2,
                        opcodeT'(code[3:0]), imm));
                    place(encode(KIND_XYI, 1'b0, 1'b0, 4'd3, 4'd3, 4'd0, OP_ADD, 12'd1));
                    n++;
                end
            end
        end
        resultEnd = resultBase + 32'(n);
        // Load a known word into r5, then store it through a computed address
        moveWord = $urandom;
        image[12'h240] = moveWord;
        place(encode(KIND_XYI, 1'b0, 1'b1, 4'd5, 4'd0, 4'd0, OP_ADD, 12'h240));
        moveAddr = expectResult(OP_SHL, 32'd5, 32'd7, 32'd0);
        place(encode(KIND_XIY, 1'b1, 1'b1, 4'd5, 4'd2, 4'd0, OP_SHL, 12'd7));
        branchTo[pc] = expectResult(OP_ADD, 32'd5, sext12(12'h19B), 32'd0);
        place(encode(KIND_XIY, 1'b0, 1'b0, 4'd15, 4'd2, 4'd0, OP_ADD, 12'h19B));
        // Throw at the branch target lands on a NOP run that ends in a self-loop
        throwVector = 5'd3;
        throwTarget = 32'h1B0;
        image[12'h1A0] = encode(KIND_THROW, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, OP_OR, 12'd3);
        image[`VECTOR_ADDR + 32'd3] = throwTarget;
        image[12'h1D0] = encode(KIND_XYI, 1'b0, 1'b0, 4'd15, 4'd0, 4'd0, OP_ADD, 12'h1D0);
        branchTo[12'h1D0] = 32'h1D0;
        image[`TRAMP_BOTTOM] = encode(KIND_XYI, 1'b0, 1'b0, 4'd15, 4'd0, 4'd0, OP_ADD, 12'h0C0);
        branchTo[`TRAMP_BOTTOM] = `TRAMP_BOTTOM;
        trapFrom = '0;

        waitForAddr(32'h1B0, 3000, "the throw target", ok);
        if (ok)
            raiseTrap(ok);
        if (ok)
            waitForAddr(`TRAMP_BOTTOM, 50, "the trap handler", ok);
        if (ok) begin
            halt = 1'b1;
            repeat (30) @(posedge clk);
        end
        endRun();
    end

endmodule

//--- list.f
+incdir+hdl
hdl/isaPkg.sv
hdl/corePkg.sv
hdl/regFile.sv
hdl/insnDecode.sv
hdl/execUnit.sv
hdl/memAccess.sv
hdl/coreSequencer.sv
hdl/cpuCore.sv
tests/clockGen.sv
tests/cpuCore_chk.sv
tests/tbTop.sv

//--- run.sh
#!/bin/sh
# Builds and runs the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f list.f -o simv

./obj_dir/simv +verilator+error+limit+1000 | tee sim.log

grep -q "ALL CHECKS PASSED" sim.log
